// ==== exec_stage.f ====
rtl/exec_uop_pkg.sv
rtl/exec_pipe_pkg.sv
rtl/exec_alu.sv
rtl/exec_mul.sv
rtl/exec_pipe_reg.sv
rtl/exec_stage.sv
tests/tb_exec_stage.sv

// ==== rtl/exec_alu.sv ====
/*
 * Integer ALU. Adder, shifter, logic ops and comparator flags.
 * Fully combinational.
 */
`timescale 1ns/1ns
`default_nettype none

module exec_alu
    import exec_uop_pkg::*;
    import exec_pipe_pkg::*;
(
    input  wire uop_t i_uop,                    // Micro-op
    input  wire word_t i_lhs,                   // Left operand
    input  wire word_t i_rhs,                   // Right operand
    output word_t     o_result,                 // ALU op result
    output word_t     o_add_result,             // lhs + rhs, always valid
    output logic      o_lt,                     // lhs < rhs
    output logic      o_eq                      // lhs == rhs
);

    logic          cmp_unsigned;                // Unsigned compare ops
    logic          lhs_ext;                     // Extension bits for compare
    logic          rhs_ext;
    logic [XLEN:0] cmp_diff;                    // One bit wider than a word
    logic [4:0]    shamt;                       // Shift amount
    word_t         add_sum;

    // Comparator ------------------
    assign cmp_unsigned = (i_uop == ALU_SLTU) ||
                          (i_uop == CFU_BLTU) ||
                          (i_uop == CFU_BGEU);

    assign lhs_ext  = !cmp_unsigned && i_lhs[XLEN-1]; // Sign or zero extend
    assign rhs_ext  = !cmp_unsigned && i_rhs[XLEN-1];
    assign cmp_diff = {lhs_ext, i_lhs} - {rhs_ext, i_rhs};

    assign o_lt = cmp_diff[XLEN];               // Sign of the true difference
    assign o_eq = (i_lhs == i_rhs);

    // Adder and shifter ------------
    assign add_sum      = i_lhs + i_rhs;
    assign o_add_result = add_sum;              // LSU and JALR addresses
    assign shamt        = i_rhs[4:0];

    // Result select
    always_comb begin
        case (i_uop)
            ALU_ADD:  o_result = add_sum;
            ALU_SUB:  o_result = cmp_diff[XLEN-1:0]; // Low bits are lhs - rhs
            ALU_XOR:  o_result = i_lhs ^ i_rhs;
            ALU_OR:   o_result = i_lhs | i_rhs;
            ALU_AND:  o_result = i_lhs & i_rhs;
            ALU_SLL:  o_result = i_lhs << shamt;
            ALU_SRL:  o_result = i_lhs >> shamt;
            ALU_SRA:  o_result = word_t'($signed(i_lhs) >>> shamt);
            ALU_SLT,
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, o_lt};
            default:  o_result = '0;            // Non-ALU uops
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/exec_mul.sv ====
/*
 * Iterative shift-and-add multiplier, 32x32 to 64 bits.
 * Retires MUL_STEP_BITS multiplier bits per cycle.
 * Handles signed, unsigned and mixed operands.
 */
`timescale 1ns/1ns
`default_nettype none

module exec_mul
    import exec_uop_pkg::*;
    import exec_pipe_pkg::*;
#(
    parameter int MUL_STEP_BITS = 4             // 1, 2, 4 or 8
) (
    input  wire        g_clk,
    input  wire        g_resetn,
    input  wire        i_valid,                 // Multiply present at input
    input  wire        i_restart,               // Transfer or flush
    input  wire uop_t  i_uop,
    input  wire word_t i_rs1,                   // Multiplicand
    input  wire word_t i_rs2,                   // Multiplier
    output word_t [1:0] o_product,              // [1] high, [0] low word
    output logic       o_ready                  // Product valid
);

    typedef enum logic [1:0] {IDLE, RUN, DONE} mul_state_t;

    mul_state_t          state;
    logic [5:0]          bit_pos;               // Multiplier bits retired
    logic [2*XLEN-1:0]   acc;                   // Running product
    logic [2*XLEN-1:0]   mcand;                 // Extended, shifted multiplicand
    logic [2*XLEN-1:0]   step_acc;              // acc after this cycle's bits
    word_t               mplier;                // Unretired multiplier bits
    logic                neg_top;               // rs2 bit 31 has negative weight
    logic                rs1_signed;
    logic                rs2_signed;
    logic                last_step;

    assign rs1_signed = (i_uop != MUL_MULHU);
    assign rs2_signed = (i_uop == MUL_MUL) || (i_uop == MUL_MULH);
    assign last_step  = (bit_pos == 6'(XLEN - MUL_STEP_BITS));

    // Add partial products for this cycle; signed rs2 subtracts its top bit
    always_comb begin
        step_acc = acc;
        for (int k = 0; k < MUL_STEP_BITS; k++) begin
            if (mplier[k]) begin
                if (neg_top && last_step && (k == MUL_STEP_BITS - 1)) begin
                    step_acc = step_acc - (mcand << k);
                end else begin
                    step_acc = step_acc + (mcand << k);
                end
            end
        end
    end

    // Control FSM ------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state   <= IDLE;
            bit_pos <= '0;
        end else if (i_restart) begin
            state   <= IDLE;                    // Abort or next instruction
            bit_pos <= '0;
        end else begin
            case (state)
                IDLE: if (i_valid) begin
                    state   <= RUN;
                    bit_pos <= '0;
                end
                RUN: begin
                    bit_pos <= bit_pos + 6'(MUL_STEP_BITS);
                    if (last_step) begin
                        state <= DONE;
                    end
                end
                default: state <= DONE;         // Hold until restart
            endcase
        end
    end

    // Datapath ----------------------
    always_ff @(posedge g_clk) begin
        if (state == IDLE) begin
            acc     <= '0;
            mcand   <= {{XLEN{rs1_signed & i_rs1[XLEN-1]}}, i_rs1};
            mplier  <= i_rs2;
            neg_top <= rs2_signed;
        end else if (state == RUN) begin
            acc    <= step_acc;
            mcand  <= mcand << MUL_STEP_BITS;
            mplier <= mplier >> MUL_STEP_BITS;
        end
    end

    assign o_product = acc;
    assign o_ready   = (state == DONE);

endmodule

`default_nettype wire

// ==== rtl/exec_pipe_pkg.sv ====
/*
 * Datapath types for the execute stage: word, register address,
 * instruction size and instruction word, plus the s3 payload width.
 */
`default_nettype none

package exec_pipe_pkg;

    localparam int XLEN = 32;                   // Datapath width

    typedef logic [XLEN-1:0] word_t;            // Operand or result
    typedef logic [4:0]      reg_addr_t;        // Register address
    typedef logic [1:0]      size_t;            // Instruction size
    typedef logic [31:0]     instr_t;           // Raw instruction word

    // s3 payload: rd, uop (5), fu (3), trap, size, instr, opr_a, opr_b
    localparam int CTRL_W = $bits(reg_addr_t) + 5 + 3 + 1 + $bits(size_t)
                          + $bits(instr_t) + 2 * XLEN;

endpackage

`default_nettype wire

// ==== rtl/exec_pipe_reg.sv ====
/*
 * One-entry pipeline register with valid/busy handshake and flush.
 */
`timescale 1ns/1ns
`default_nettype none

module exec_pipe_reg #(
    parameter int WIDTH = 32                    // Payload width
) (
    input  wire              g_clk,
    input  wire              g_resetn,
    input  wire [WIDTH-1:0]  i_data,            // Payload from this stage
    input  wire              i_valid,           // Load request
    input  wire              i_flush,           // Drop held and incoming item
    input  wire              i_busy,            // Consumer stalled
    output logic [WIDTH-1:0] o_data,
    output logic             o_valid,           // Item held
    output logic             o_busy             // Full and blocked
);

    logic load;

    assign o_busy = o_valid && i_busy;
    assign load   = i_valid && !o_busy;         // Transfer into register

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;                    // Flush wins over load
        end else if (load) begin
            o_valid <= 1'b1;
        end else if (!i_busy) begin
            o_valid <= 1'b0;                    // Consumed, nothing new
        end
    end

    // Payload
    always_ff @(posedge g_clk) begin
        if (load) begin
            o_data <= i_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exec_stage.sv ====
/*
 * Execute stage top. Unit operand selection, branch resolution,
 * multiply stall and the s3 output register.
 */
`timescale 1ns/1ns
`default_nettype none

module exec_stage
    import exec_uop_pkg::*;
    import exec_pipe_pkg::*;
#(
    parameter int MUL_STEP_BITS = 4             // Multiplier bits per cycle
) (
    input  wire            g_clk,
    input  wire            g_resetn,
    input  wire reg_addr_t i_s2_rd,             // Dest reg, trap cause if trap
    input  wire word_t     i_s2_opr_a,
    input  wire word_t     i_s2_opr_b,
    input  wire word_t     i_s2_opr_c,
    input  wire uop_t      i_s2_uop,
    input  wire fu_t       i_s2_fu,
    input  wire            i_s2_trap,
    input  wire size_t     i_s2_size,
    input  wire instr_t    i_s2_instr,
    input  wire            i_s2_valid,
    output logic           o_s2_busy,           // Stall decode
    input  wire            i_flush,
    output reg_addr_t      o_s3_rd,
    output word_t          o_s3_opr_a,
    output word_t          o_s3_opr_b,
    output uop_t           o_s3_uop,
    output fu_t            o_s3_fu,
    output logic           o_s3_trap,
    output size_t          o_s3_size,
    output instr_t         o_s3_instr,
    output logic           o_s3_valid,
    input  wire            i_s3_busy            // Writeback stalled
);

    // Payload bit offsets, opr_b at the bottom
    localparam int OA_LSB  = XLEN;
    localparam int IN_LSB  = 2 * XLEN;
    localparam int SZ_LSB  = IN_LSB + $bits(instr_t);
    localparam int TR_LSB  = SZ_LSB + $bits(size_t);
    localparam int FU_LSB  = TR_LSB + 1;
    localparam int UOP_LSB = FU_LSB + $bits(fu_t);
    localparam int RD_LSB  = UOP_LSB + $bits(uop_t);

    word_t              alu_result;
    word_t              alu_add;
    logic               alu_lt;
    logic               alu_eq;
    word_t [1:0]        mul_product;            // [1] high word
    logic               mul_ready;
    logic               mul_present;            // Multiply waiting in s2
    logic               p_valid;                // s2 transfer this cycle
    logic               p_busy;                 // Output register blocked
    logic               cfu_cond;               // Conditional branch
    logic               cond_taken;
    uop_t               n_uop;
    word_t              n_opr_a;
    word_t              n_opr_b;
    logic [CTRL_W-1:0]  pipe_in;
    logic [CTRL_W-1:0]  pipe_out;

    // Handshake ---------------------
    assign mul_present = i_s2_valid && (i_s2_fu == FU_MUL);
    assign o_s2_busy   = p_busy || (mul_present && !mul_ready);
    assign p_valid     = i_s2_valid && !o_s2_busy;

    // Branch resolution -------------
    assign cfu_cond = (i_s2_fu == FU_CFU) &&
                      (i_s2_uop inside {CFU_BEQ, CFU_BNE, CFU_BLT,
                                        CFU_BGE, CFU_BLTU, CFU_BGEU});

    always_comb begin
        case (i_s2_uop)
            CFU_BEQ:          cond_taken = alu_eq;
            CFU_BNE:          cond_taken = !alu_eq;
            CFU_BLT, CFU_BLTU: cond_taken = alu_lt;  // ALU picks signedness
            default:          cond_taken = !alu_lt; // BGE, BGEU
        endcase
    end

    assign n_uop = cfu_cond ? (cond_taken ? CFU_TAKEN : CFU_NOT_TAKEN) : i_s2_uop;

    // Operand select ----------------
    always_comb begin
        case (i_s2_fu)
            FU_ALU: n_opr_a = alu_result;
            FU_MUL: n_opr_a = (i_s2_uop == MUL_MUL) ? mul_product[0] : mul_product[1];
            FU_LSU: n_opr_a = alu_add;          // Memory address
            FU_CFU: n_opr_a = (i_s2_uop == CFU_JALR) ? {alu_add[XLEN-1:1], 1'b0}
                                                     : {i_s2_opr_c[XLEN-1:1], 1'b0};
            default: n_opr_a = i_s2_opr_a;      // CSR pass-through
        endcase
    end

    always_comb begin
        if (i_s2_trap) begin
            n_opr_b = word_t'(i_s2_rd);         // Trap cause
        end else begin
            case (i_s2_fu)
                FU_MUL:         n_opr_b = mul_product[1];
                FU_LSU, FU_CSR: n_opr_b = i_s2_opr_c; // Store data or CSR operand
                default:        n_opr_b = '0;
            endcase
        end
    end

    // Units -------------------------
    exec_alu alu_inst (
        .i_uop        (i_s2_uop),
        .i_lhs        (i_s2_opr_a),
        .i_rhs        (i_s2_opr_b),
        .o_result     (alu_result),
        .o_add_result (alu_add),
        .o_lt         (alu_lt),
        .o_eq         (alu_eq)
    );

    exec_mul #(.MUL_STEP_BITS(MUL_STEP_BITS)) mul_inst (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .i_valid   (mul_present),
        .i_restart (p_valid || i_flush),        // Done with it, or aborted
        .i_uop     (i_s2_uop),
        .i_rs1     (i_s2_opr_a),
        .i_rs2     (i_s2_opr_b),
        .o_product (mul_product),
        .o_ready   (mul_ready)
    );

    // Output register ---------------
    assign pipe_in = {i_s2_rd, n_uop, i_s2_fu, i_s2_trap, i_s2_size,
                      i_s2_instr, n_opr_a, n_opr_b};

    exec_pipe_reg #(.WIDTH(CTRL_W)) pipe_reg_inst (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_data   (pipe_in),
        .i_valid  (p_valid),
        .i_flush  (i_flush),
        .i_busy   (i_s3_busy),
        .o_data   (pipe_out),
        .o_valid  (o_s3_valid),
        .o_busy   (p_busy)
    );

    assign o_s3_rd    = pipe_out[RD_LSB +: $bits(reg_addr_t)];
    assign o_s3_uop   = uop_t'(pipe_out[UOP_LSB +: $bits(uop_t)]);
    assign o_s3_fu    = fu_t'(pipe_out[FU_LSB +: $bits(fu_t)]);
    assign o_s3_trap  = pipe_out[TR_LSB];
    assign o_s3_size  = pipe_out[SZ_LSB +: $bits(size_t)];
    assign o_s3_instr = pipe_out[IN_LSB +: $bits(instr_t)];
    assign o_s3_opr_a = pipe_out[OA_LSB +: XLEN];
    assign o_s3_opr_b = pipe_out[XLEN-1:0];

endmodule

`default_nettype wire

// ==== rtl/exec_uop_pkg.sv ====
/*
 * Functional unit and micro-op encodings for the execute stage.
 * Micro-op codes are unique across all units.
 */
`default_nettype none

package exec_uop_pkg;

    // Functional unit select ------
    typedef enum logic [2:0] {
        FU_ALU = 3'd0,                          // Integer ALU
        FU_MUL = 3'd1,                          // Multi-cycle multiplier
        FU_LSU = 3'd2,                          // Load/store address gen
        FU_CFU = 3'd3,                          // Branches and jumps
        FU_CSR = 3'd4                           // CSR access
    } fu_t;

    // Micro-ops ------------------
    typedef enum logic [4:0] {
        ALU_ADD       = 5'd0,
        ALU_SUB       = 5'd1,
        ALU_XOR       = 5'd2,
        ALU_OR        = 5'd3,
        ALU_AND       = 5'd4,
        ALU_SLL       = 5'd5,
        ALU_SRL       = 5'd6,
        ALU_SRA       = 5'd7,
        ALU_SLT       = 5'd8,
        ALU_SLTU      = 5'd9,
        MUL_MUL       = 5'd10,                  // Low word
        MUL_MULH      = 5'd11,                  // High word, signed x signed
        MUL_MULHU     = 5'd12,                  // High word, unsigned x unsigned
        MUL_MULHSU    = 5'd13,                  // High word, signed x unsigned
        LSU_LOAD      = 5'd14,
        LSU_STORE     = 5'd15,
        CFU_BEQ       = 5'd16,
        CFU_BNE       = 5'd17,
        CFU_BLT       = 5'd18,
        CFU_BGE       = 5'd19,
        CFU_BLTU      = 5'd20,
        CFU_BGEU      = 5'd21,
        CFU_JALI      = 5'd22,                  // Jump, target in operand C
        CFU_JALR      = 5'd23,                  // Jump, target is A + B
        CFU_TAKEN     = 5'd24,                  // Resolved branch outcomes
        CFU_NOT_TAKEN = 5'd25,                  // Only ever driven on s3
        CSR_OP        = 5'd26
    } uop_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the execute stage testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_exec_stage -f exec_stage.f -o sim_exec_stage \
    && ./obj_dir/sim_exec_stage > sim.log 2>&1 \
    || { echo "Build or simulation run error, see sim.log"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation reported errors"; exit 1; } \
    || { echo "Simulation clean"; exit 0; }

// ==== tests/tb_exec_stage.sv ====
/*
 * Execute stage testbench. LFSR random instructions, random s3 stalls
 * and flushes, a queue-based model of the s3 record, compare tasks.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_exec_stage
    import exec_uop_pkg::*;
    import exec_pipe_pkg::*;
();

    localparam int NUM_INSTR   = 300;
    localparam int CYCLE_LIMIT = NUM_INSTR * 80;    // Worst case per instruction

    typedef struct packed {
        int        idx;                         // Instruction number
        reg_addr_t rd;
        word_t     opr_a;
        word_t     opr_b;
        uop_t      uop;
        fu_t       fu;
        logic      trap;
        size_t     size;
        instr_t    instr;
    } s3_rec_t;

    logic      g_clk;
    logic      g_resetn;
    reg_addr_t i_s2_rd;
    word_t     i_s2_opr_a;
    word_t     i_s2_opr_b;
    word_t     i_s2_opr_c;
    uop_t      i_s2_uop;
    fu_t       i_s2_fu;
    logic      i_s2_trap;
    size_t     i_s2_size;
    instr_t    i_s2_instr;
    logic      i_s2_valid;
    logic      o_s2_busy;
    logic      i_flush;
    reg_addr_t o_s3_rd;
    word_t     o_s3_opr_a;
    word_t     o_s3_opr_b;
    uop_t      o_s3_uop;
    fu_t       o_s3_fu;
    logic      o_s3_trap;
    size_t     o_s3_size;
    instr_t    o_s3_instr;
    logic      o_s3_valid;
    logic      i_s3_busy;

    logic [31:0] lfsr_state;                    // Fibonacci LFSR with taps 32 22 2 1
    s3_rec_t     exp_q[$];                      // Expected s3 records in order
    int          check_errs = 0;
    int          proto_errs = 0;                // Handshake and timeout errors
    int          n_done = 0;                    // Accepted or dropped instructions
    int          cycles = 0;
    logic        timed_out = 1'b0;
    logic        need_new;
    logic        accepted;
    logic        back_press;                    // Model holds a result and s3 is busy

    exec_stage #(.MUL_STEP_BITS(4)) exec_stage_inst (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .i_s2_rd    (i_s2_rd),
        .i_s2_opr_a (i_s2_opr_a),
        .i_s2_opr_b (i_s2_opr_b),
        .i_s2_opr_c (i_s2_opr_c),
        .i_s2_uop   (i_s2_uop),
        .i_s2_fu    (i_s2_fu),
        .i_s2_trap  (i_s2_trap),
        .i_s2_size  (i_s2_size),
        .i_s2_instr (i_s2_instr),
        .i_s2_valid (i_s2_valid),
        .o_s2_busy  (o_s2_busy),
        .i_flush    (i_flush),
        .o_s3_rd    (o_s3_rd),
        .o_s3_opr_a (o_s3_opr_a),
        .o_s3_opr_b (o_s3_opr_b),
        .o_s3_uop   (o_s3_uop),
        .o_s3_fu    (o_s3_fu),
        .o_s3_trap  (o_s3_trap),
        .o_s3_size  (o_s3_size),
        .o_s3_instr (o_s3_instr),
        .o_s3_valid (o_s3_valid),
        .i_s3_busy  (i_s3_busy)
    );

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;              // 4 ns period
    end

    // Random source ---------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};         // One step per bit
        end
        return v;
    endfunction

    task automatic gen_instr();
        logic [2:0] fsel;
        fsel       = 3'(rand_bits(3));
        i_s2_opr_a = rand_bits(32);
        i_s2_opr_b = (rand_bits(2) == 0) ? i_s2_opr_a : rand_bits(32); // Equal now and then
        i_s2_opr_c = rand_bits(32);
        i_s2_rd    = 5'(rand_bits(5));
        i_s2_size  = 2'(rand_bits(2));
        i_s2_instr = rand_bits(32);
        i_s2_trap  = (rand_bits(4) == 0);
        case (fsel)
            3'd3, 3'd7: begin                   // Multiplies twice as often
                i_s2_fu  = FU_MUL;
                i_s2_uop = uop_t'(5'(MUL_MUL + rand_bits(2)));
            end
            3'd4: begin
                i_s2_fu  = FU_LSU;
                i_s2_uop = uop_t'(5'(LSU_LOAD + rand_bits(1)));
            end
            3'd5: begin
                i_s2_fu  = FU_CFU;
                i_s2_uop = uop_t'(5'(CFU_BEQ + rand_bits(3))); // Branches, JALI, JALR
            end
            3'd6: begin
                i_s2_fu  = FU_CSR;
                i_s2_uop = CSR_OP;
            end
            default: begin
                i_s2_fu  = FU_ALU;
                i_s2_uop = uop_t'(5'(rand_bits(4) % 10));
            end
        endcase
    endtask

    // Reference model --------------
    function automatic s3_rec_t model_s3(input int idx);
        s3_rec_t     r;
        logic [63:0] ext_a;
        logic [63:0] ext_b;
        logic [63:0] prod;
        logic        taken;
        word_t       a;
        word_t       b;
        a       = i_s2_opr_a;
        b       = i_s2_opr_b;
        r.idx   = idx;
        r.rd    = i_s2_rd;
        r.uop   = i_s2_uop;
        r.fu    = i_s2_fu;
        r.trap  = i_s2_trap;
        r.size  = i_s2_size;
        r.instr = i_s2_instr;
        r.opr_b = '0;
        // Extended operands give the product modulo 2**64
        ext_a = (i_s2_uop == MUL_MULHU) ? {32'b0, a} : {{32{a[31]}}, a};
        ext_b = (i_s2_uop == MUL_MUL || i_s2_uop == MUL_MULH) ? {{32{b[31]}}, b} : {32'b0, b};
        prod  = ext_a * ext_b;
        case (i_s2_uop)
            CFU_BEQ:  taken = (a == b);
            CFU_BNE:  taken = (a != b);
            CFU_BLT:  taken = ($signed(a) < $signed(b));
            CFU_BGE:  taken = ($signed(a) >= $signed(b));
            CFU_BLTU: taken = (a < b);
            default:  taken = (a >= b);         // BGEU
        endcase
        case (i_s2_fu)
            FU_ALU: begin
                case (i_s2_uop)
                    ALU_ADD: r.opr_a = a + b;
                    ALU_SUB: r.opr_a = a - b;
                    ALU_XOR: r.opr_a = a ^ b;
                    ALU_OR:  r.opr_a = a | b;
                    ALU_AND: r.opr_a = a & b;
                    ALU_SLL: r.opr_a = a << b[4:0];
                    ALU_SRL: r.opr_a = a >> b[4:0];
                    ALU_SRA: r.opr_a = word_t'($signed(a) >>> b[4:0]);
                    ALU_SLT: r.opr_a = word_t'($signed(a) < $signed(b));
                    default: r.opr_a = word_t'(a < b); // SLTU
                endcase
            end
            FU_MUL: begin
                r.opr_a = (i_s2_uop == MUL_MUL) ? prod[31:0] : prod[63:32];
                r.opr_b = prod[63:32];
            end
            FU_LSU: begin
                r.opr_a = a + b;                // Address and store data
                r.opr_b = i_s2_opr_c;
            end
            FU_CFU: begin
                if (i_s2_uop == CFU_JALR) begin
                    r.opr_a = (a + b) & ~32'd1;
                end else begin
                    r.opr_a = i_s2_opr_c & ~32'd1;
                end
                if (i_s2_uop != CFU_JALI && i_s2_uop != CFU_JALR) begin
                    r.uop = taken ? CFU_TAKEN : CFU_NOT_TAKEN;
                end
            end
            default: begin
                r.opr_a = a;                    // CSR pass-through
                r.opr_b = i_s2_opr_c;
            end
        endcase
        if (i_s2_trap) begin
            r.opr_b = {27'b0, i_s2_rd};         // Trap cause
        end
        return r;
    endfunction

    // Compare tasks -----------------
    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_uop(input string name, input uop_t exp, input uop_t act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_fu(input string name, input fu_t exp, input fu_t act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_size(input string name, input size_t exp, input size_t act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_instr(input string name, input instr_t exp, input instr_t act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_rec(input s3_rec_t e);
        string tag;
        tag = $sformatf("instr %0d", e.idx);
        check_word({tag, " opr_a"}, e.opr_a, o_s3_opr_a);
        check_word({tag, " opr_b"}, e.opr_b, o_s3_opr_b);
        check_uop({tag, " uop"}, e.uop, o_s3_uop);
        check_fu({tag, " fu"}, e.fu, o_s3_fu);
        check_bit({tag, " trap"}, e.trap, o_s3_trap);
        check_reg({tag, " rd"}, e.rd, o_s3_rd);
        check_size({tag, " size"}, e.size, o_s3_size);
        check_instr({tag, " instr"}, e.instr, o_s3_instr);
    endtask

    // Sample at mid-cycle and advance the model over the coming edge
    task automatic observe_edge(output logic acc);
        acc = 1'b0;
        if (exp_q.size() == 0) begin
            if (o_s3_valid !== 1'b0) begin
                proto_errs++;
                $display("Output valid with no result outstanding");
            end
        end else if (o_s3_valid !== 1'b1) begin
            proto_errs++;
            $display("Output not valid while a result is outstanding");
        end else begin
            compare_rec(exp_q[0]);              // Held output must not move
        end
        if (i_flush) begin
            exp_q.delete();                     // Held result dropped
        end else begin
            if (exp_q.size() != 0 && !i_s3_busy) begin
                exp_q.delete(0);                // Taken by writeback
            end
            if (i_s2_valid && !o_s2_busy) begin
                exp_q.push_back(model_s3(n_done));
                acc = 1'b1;
            end
        end
    endtask

    task automatic tick_timeout();
        cycles++;
        if (cycles >= CYCLE_LIMIT && !timed_out) begin
            timed_out = 1'b1;
            proto_errs++;
            $display("Timeout after %0d cycles with %0d instructions done", cycles, n_done);
        end
    endtask

    // Stimulus ------------------------
    initial begin
        lfsr_state = 32'hf856906d;
        g_resetn   = 1'b0;
        i_s2_rd    = '0;
        i_s2_opr_a = '0;
        i_s2_opr_b = '0;
        i_s2_opr_c = '0;
        i_s2_uop   = ALU_ADD;
        i_s2_fu    = FU_ALU;
        i_s2_trap  = 1'b0;
        i_s2_size  = '0;
        i_s2_instr = '0;
        i_s2_valid = 1'b0;
        i_flush    = 1'b0;
        i_s3_busy  = 1'b0;
        repeat (2) @(posedge g_clk);
        #1 g_resetn = 1'b1;
        @(negedge g_clk);
        if (o_s3_valid || o_s2_busy) begin
            proto_errs++;
            $display("Output valid or stall set right after reset");
        end
        need_new = 1'b1;
        while (n_done < NUM_INSTR && !timed_out) begin
            @(posedge g_clk);
            #1;
            if (need_new) begin
                gen_instr();
                need_new = 1'b0;
            end
            i_flush    = (rand_bits(5) == 0);   // About one cycle in 32
            i_s2_valid = !i_flush;
            i_s3_busy  = (rand_bits(2) == 0);   // One in four
            @(negedge g_clk);
            back_press = (exp_q.size() != 0) && i_s3_busy;
            if (i_s2_valid && i_s2_fu != FU_MUL && o_s2_busy && !back_press) begin
                proto_errs++;
                $display("Instruction %0d stalled with no back-pressure", n_done);
            end
            if (i_s2_valid && back_press && !o_s2_busy) begin
                proto_errs++;
                $display("Instruction %0d accepted into a blocked output register", n_done);
            end
            observe_edge(accepted);
            if (accepted || (i_flush && i_s2_fu == FU_MUL)) begin
                n_done++;                       // A flushed multiply is gone
                need_new = 1'b1;
            end
            tick_timeout();
        end
        // Drain the output register
        while (exp_q.size() != 0 && !timed_out) begin
            @(posedge g_clk);
            #1;
            i_s2_valid = 1'b0;
            i_flush    = 1'b0;
            i_s3_busy  = 1'b0;
            @(negedge g_clk);
            observe_edge(accepted);
            tick_timeout();
        end
        $display("Errors: %0d check failures, %0d protocol or timeout errors",
                 check_errs, proto_errs);
        if (check_errs == 0 && proto_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
